//--- design/copad_pkg.sv
// co-pad trigger shared definitions
// widths, the two-way cluster word, readout word layout and FEB map constants
`default_nettype none

package copad_pkg;

  // ---------------------
  // cluster word
  // ---------------------
  parameter int adr_width       = 11; // pad address
  parameter int cnt_width       = 3;  // additional pads hit, carried through untouched
  parameter int cluster_width   = 14;
  parameter int feb_sel_width   = 6;  // upper address bits select the board
  parameter int strip_width     = cluster_width - cnt_width - feb_sel_width;

  // one 14 bit cluster, read as a hit (count + address) or as a pad location
  typedef union packed {
    struct packed {
      logic [cnt_width-1:0] cnt;
      logic [adr_width-1:0] adr;
    } as_hit;
    struct packed {
      logic [cnt_width-1:0]     cnt;
      logic [feb_sel_width-1:0] feb_sel; // same bits as adr[10:5]
      logic [strip_width-1:0]   strip;
    } as_pad;
  } cluster_word_t;

  // ---------------------
  // matching geometry
  // ---------------------
  parameter int neighbor_offset = 8;   // side match step
  parameter int partition_pads  = 192; // left edges are multiples of this
  parameter int n_left_edges    = 8;   // 0 .. 1344
  parameter int n_right_edges   = 7;
  // right edges, last partition is the odd one out
  parameter logic [n_right_edges-1:0][adr_width-1:0] right_edges = {
    11'd1528, 11'd1144, 11'd952, 11'd760, 11'd568, 11'd376, 11'd184
  };

  // ---------------------
  // FEB map
  // ---------------------
  parameter int n_febs       = 24; // id n_febs means no board
  parameter int feb_id_width = 5;
  parameter int feb_rows     = 8;  // chamber is 8 rows x 3 columns
  parameter int feb_cols     = 3;

  // ---------------------
  // readout word
  // ---------------------
  parameter int tag_width       = 6; // event tag, wraps
  parameter int readout_width   = 32;
  parameter int kind_width      = 2;
  parameter int idx_width       = 3; // cluster index field in a record
  parameter int record_pad_bits = 5; // zero fill at the bottom of a record
  parameter logic [kind_width-1:0] kind_record  = 2'b01;
  parameter logic [kind_width-1:0] kind_summary = 2'b10;

endpackage

`default_nettype wire

//--- design/copad_matcher.sv
// co-pad matcher
// compares each layer-0 cluster against all layer-1 clusters, exact and +/-8,
// registers the result with the layer-0 words, the FEB ids and the event tag
`default_nettype none
`timescale 1ns/1ns

module copad_matcher
  import copad_pkg::*;
#(
  parameter int n_clusters = 8
) (
  input  logic                                      clock,
  input  logic                                      reset,
  input  logic                                      event_valid,
  output logic                                      event_ready,
  input  cluster_word_t [n_clusters-1:0]            gem0_clusters,
  input  cluster_word_t [n_clusters-1:0]            gem1_clusters,
  input  logic                                      match_neighbors,
  output logic                                      res_valid,
  output logic [tag_width-1:0]                      res_tag,
  output cluster_word_t [n_clusters-1:0]            res_clusters,
  output logic [n_clusters-1:0]                     res_match,
  output logic [n_clusters-1:0]                     res_left,
  output logic [n_clusters-1:0]                     res_right,
  output logic [n_clusters-1:0][feb_id_width-1:0]   res_feb_ids,
  input  logic                                      ser_ready,
  input  logic                                      sum_ready
);

  logic [n_clusters-1:0]                   vld1;       // layer-1 cluster not blank
  logic [n_clusters-1:0]                   hit_c;      // centre match
  logic [n_clusters-1:0]                   hit_l;      // match at adr-8
  logic [n_clusters-1:0]                   hit_r;      // match at adr+8
  logic [n_clusters-1:0]                   match_fast;
  logic [n_clusters-1:0][feb_id_width-1:0] feb_id;
  logic [tag_width-1:0]                    tag_cnt;    // tag of the next accepted event
  logic                                    res_full;   // a result is held
  logic                                    accept;

  // blank clusters sit above 1535, address bits 10:9 both set
  for (genvar j = 0; j < n_clusters; j++) begin : g_vld1
    assign vld1[j] = ~&gem1_clusters[j].as_hit.adr[adr_width-1:adr_width-2];
  end

  // --------------------
  // per cluster matching
  // --------------------
  for (genvar i = 0; i < n_clusters; i++) begin : g_match
    logic [adr_width-1:0]     adr;
    logic [adr_width-1:0]     adr_m;
    logic [adr_width-1:0]     adr_p;
    logic [feb_sel_width-1:0] sel;
    logic                     vld0;
    logic                     any_c;
    logic                     any_l;
    logic                     any_r;
    logic                     left_edge;
    logic                     right_edge;

    assign adr   = gem0_clusters[i].as_hit.adr;
    assign adr_m = adr - adr_width'(neighbor_offset);
    assign adr_p = adr + adr_width'(neighbor_offset);
    assign vld0  = ~&adr[adr_width-1:adr_width-2];
    assign sel   = gem0_clusters[i].as_pad.feb_sel;

    always_comb begin
      any_c      = 1'b0;
      any_l      = 1'b0;
      any_r      = 1'b0;
      left_edge  = 1'b0;
      right_edge = 1'b0;
      for (int j = 0; j < n_clusters; j++) begin
        if (vld1[j]) begin // blank layer-1 words never pair up
          any_c = any_c | (adr   == gem1_clusters[j].as_hit.adr);
          any_l = any_l | (adr_m == gem1_clusters[j].as_hit.adr);
          any_r = any_r | (adr_p == gem1_clusters[j].as_hit.adr);
        end
      end
      for (int k = 0; k < n_left_edges; k++) begin
        if (adr == adr_width'(k * partition_pads))
          left_edge = 1'b1;
      end
      for (int k = 0; k < n_right_edges; k++) begin
        if (adr == right_edges[k])
          right_edge = 1'b1;
      end
    end

    assign hit_c[i] = vld0 & any_c;
    assign hit_l[i] = vld0 & any_l & ~left_edge;  // nothing left of a partition start
    assign hit_r[i] = vld0 & any_r & ~right_edge; // nor right of its end

    // rows run down the columns, board = (sel mod 3)*8 + sel div 3
    assign feb_id[i] = (sel < feb_sel_width'(n_febs))
                     ? feb_id_width'((int'(sel) % feb_cols) * feb_rows + int'(sel) / feb_cols)
                     : feb_id_width'(n_febs); // no board
  end

  assign match_fast = hit_c | ({n_clusters{match_neighbors}} & (hit_l | hit_r));

  // --------------------
  // handshake and tag
  // --------------------
  // result is offered only when both producers can take it, so both see the same event
  assign res_valid   = res_full & ser_ready & sum_ready;
  assign event_ready = ~res_full | res_valid;
  assign accept      = event_valid & event_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      res_full <= 1'b0;
      tag_cnt  <= '0;
    end else begin
      if (accept) begin
        res_full <= 1'b1;
        tag_cnt  <= tag_cnt + 1'b1; // wraps at 64
      end else if (res_valid) begin
        res_full <= 1'b0;
      end
    end
  end

  // result registers, 1bx behind the accepted event
  always_ff @(posedge clock) begin
    if (accept) begin
      res_tag      <= tag_cnt;
      res_clusters <= gem0_clusters;
      res_match    <= match_fast;
      res_left     <= hit_l; // raw side matches
      res_right    <= hit_r;
      res_feb_ids  <= feb_id;
    end
  end

endmodule

`default_nettype wire

//--- design/copad_serializer.sv
// co-pad record serializer
// holds one matched event and emits one readout record per matched layer-0
// cluster, lowest index first
`default_nettype none
`timescale 1ns/1ns

module copad_serializer
  import copad_pkg::*;
#(
  parameter int n_clusters = 8
) (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           res_valid,
  input  logic [tag_width-1:0]           res_tag,
  input  cluster_word_t [n_clusters-1:0] res_clusters,
  input  logic [n_clusters-1:0]          res_match,
  input  logic [n_clusters-1:0]          res_left,
  input  logic [n_clusters-1:0]          res_right,
  output logic                           ser_ready,
  output logic                           req_valid,
  output logic [readout_width-1:0]       req_data,
  input  logic                           req_ready
);

  logic [n_clusters-1:0]          pending;    // records still to send
  logic [n_clusters-1:0]          first;      // lowest pending bit, one-hot
  logic [tag_width-1:0]           tag_q;
  cluster_word_t [n_clusters-1:0] clusters_q;
  logic [n_clusters-1:0]          left_q;
  logic [n_clusters-1:0]          right_q;
  logic                           take;

  assign ser_ready = ~|pending;             // idle once the mask is drained
  assign req_valid = |pending;
  assign take      = res_valid & ser_ready;

  // isolate lowest set bit
  assign first = pending & (~pending + n_clusters'(1));

  // --------------------
  // pending mask
  // --------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      pending <= '0;
    end else if (take) begin
      pending <= res_match;                 // empty mask keeps us ready
    end else if (req_valid && req_ready) begin
      pending <= pending & ~first;          // drop the record just sent
    end
  end

  // event payload, held until the mask drains
  always_ff @(posedge clock) begin
    if (take) begin
      tag_q      <= res_tag;
      clusters_q <= res_clusters;
      left_q     <= res_left;
      right_q    <= res_right;
    end
  end

  // --------------------
  // record word
  // --------------------
  // walk down so the lowest pending index wins
  always_comb begin
    req_data = '0;
    for (int i = n_clusters - 1; i >= 0; i--) begin
      if (pending[i]) begin
        req_data = {kind_record,
                    tag_q,
                    idx_width'(i),           // cluster index
                    left_q[i],
                    right_q[i],
                    clusters_q[i],           // count and address as received
                    {record_pad_bits{1'b0}}};
      end
    end
  end

endmodule

`default_nettype wire

//--- design/feb_summary.sv
// FEB summary producer
// ORs the board ids of matched clusters into a 24 bit list and offers one
// summary word per event that has any match
`default_nettype none
`timescale 1ns/1ns

module feb_summary
  import copad_pkg::*;
#(
  parameter int n_clusters = 8
) (
  input  logic                                    clock,
  input  logic                                    reset,
  input  logic                                    res_valid,
  input  logic [tag_width-1:0]                    res_tag,
  input  logic [n_clusters-1:0]                   res_match,
  input  logic [n_clusters-1:0][feb_id_width-1:0] res_feb_ids,
  output logic                                    sum_ready,
  output logic                                    req_valid,
  output logic [readout_width-1:0]                req_data,
  input  logic                                    req_ready
);

  logic [n_febs-1:0] feb_list; // active boards of this event
  logic              take;

  assign sum_ready = ~req_valid;            // one summary held at a time
  assign take      = res_valid & sum_ready;

  // id n_febs is the no-board code and sets nothing
  always_comb begin
    feb_list = '0;
    for (int i = 0; i < n_clusters; i++) begin
      if (res_match[i] && (res_feb_ids[i] < feb_id_width'(n_febs)))
        feb_list[res_feb_ids[i]] = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      req_valid <= 1'b0;
    end else if (take) begin
      req_valid <= |res_match;              // silent for events with no match
    end else if (req_ready) begin
      req_valid <= 1'b0;
    end
  end

  // summary word held until accepted
  always_ff @(posedge clock) begin
    if (take)
      req_data <= {kind_summary, res_tag, feb_list};
  end

endmodule

`default_nettype wire

//--- design/readout_arbiter.sv
// readout arbiter
// round-robin share of the 32 bit readout stream between record and summary
// producers, grant locked while the granted word waits
`default_nettype none
`timescale 1ns/1ns

module readout_arbiter
  import copad_pkg::*;
(
  input  logic                          clock,
  input  logic                          reset,
  input  logic [1:0]                    req_valid,
  input  logic [1:0][readout_width-1:0] req_data,
  output logic [1:0]                    req_ready,
  output logic                          out_valid,
  output logic [readout_width-1:0]      out_data,
  input  logic                          out_ready
);

  logic prio;     // producer preferred at the next free pick
  logic locked;   // granted word not yet taken
  logic lock_sel;
  logic grant;

  always_comb begin
    if (locked)
      grant = lock_sel;        // hold so out_data stays put
    else if (req_valid[prio])
      grant = prio;
    else
      grant = ~prio;
  end

  // data path is pure muxing
  assign out_valid    = req_valid[grant];
  assign out_data     = req_data[grant];
  assign req_ready[0] = out_ready & ~grant;
  assign req_ready[1] = out_ready & grant;

  always_ff @(posedge clock) begin
    if (reset) begin
      prio     <= 1'b0;
      locked   <= 1'b0;
      lock_sel <= 1'b0;
    end else if (out_valid) begin
      if (out_ready) begin
        locked <= 1'b0;
        prio   <= ~grant;      // other side goes first next time
      end else begin
        locked   <= 1'b1;
        lock_sel <= grant;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/copad_trigger_top.sv
// co-pad trigger slice top
// matcher feeding record serializer and FEB summary, merged onto one readout stream
`default_nettype none
`timescale 1ns/1ns

module copad_trigger_top
  import copad_pkg::*;
#(
  parameter int n_clusters = 8
) (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           event_valid,
  output logic                           event_ready,
  input  cluster_word_t [n_clusters-1:0] gem0_clusters,
  input  cluster_word_t [n_clusters-1:0] gem1_clusters,
  input  logic                           match_neighbors,
  output logic                           out_valid,
  output logic [readout_width-1:0]       out_data,
  input  logic                           out_ready
);

  // --------------------
  // matcher result bus
  // --------------------
  logic                                    res_valid;
  logic [tag_width-1:0]                    res_tag;
  cluster_word_t [n_clusters-1:0]          res_clusters;
  logic [n_clusters-1:0]                   res_match;
  logic [n_clusters-1:0]                   res_left;
  logic [n_clusters-1:0]                   res_right;
  logic [n_clusters-1:0][feb_id_width-1:0] res_feb_ids;
  logic                                    ser_ready;
  logic                                    sum_ready;

  // producer requests, 0 = records, 1 = summary
  logic [1:0]                    req_valid;
  logic [1:0][readout_width-1:0] req_data;
  logic [1:0]                    req_ready;

  copad_matcher #(.n_clusters(n_clusters)) matcher_i (
    .clock, .reset, .event_valid, .event_ready, .gem0_clusters, .gem1_clusters,
    .match_neighbors, .res_valid, .res_tag, .res_clusters, .res_match,
    .res_left, .res_right, .res_feb_ids, .ser_ready, .sum_ready
  );

  copad_serializer #(.n_clusters(n_clusters)) serializer_i (
    .clock, .reset, .res_valid, .res_tag, .res_clusters, .res_match,
    .res_left, .res_right, .ser_ready,
    .req_valid(req_valid[0]), .req_data(req_data[0]), .req_ready(req_ready[0])
  );

  feb_summary #(.n_clusters(n_clusters)) summary_i (
    .clock, .reset, .res_valid, .res_tag, .res_match, .res_feb_ids, .sum_ready,
    .req_valid(req_valid[1]), .req_data(req_data[1]), .req_ready(req_ready[1])
  );

  readout_arbiter arbiter_i (
    .clock, .reset, .req_valid, .req_data, .req_ready, .out_valid, .out_data, .out_ready
  );

endmodule

`default_nettype wire

//--- verification/copad_trigger_assertions.sv
// handshake checks on the co-pad trigger top, bound into the top level
`default_nettype none
`timescale 1ns/1ns

module copad_trigger_assertions
  import copad_pkg::*;
(
  input logic                     clock,
  input logic                     reset,
  input logic                     event_ready,
  input logic                     out_valid,
  input logic [readout_width-1:0] out_data,
  input logic                     out_ready
);

  int failures = 0; // summed into the testbench error count

  // a stalled word stays offered and unchanged
  hold_while_stalled: assert property (
    @(posedge clock) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_data)
  ) else begin
    failures = failures + 1;
    $error("readout word changed while stalled");
  end

  ready_after_reset: assert property (
    @(posedge clock) $fell(reset) |-> event_ready
  ) else begin
    failures = failures + 1;
    $error("event_ready low in first cycle after reset");
  end

  // only record and summary kinds exist
  legal_kind: assert property (
    @(posedge clock) disable iff (reset)
    out_valid |-> (out_data[readout_width-1 -: kind_width] == kind_record ||
                   out_data[readout_width-1 -: kind_width] == kind_summary)
  ) else begin
    failures = failures + 1;
    $error("illegal kind field on readout word");
  end

endmodule

bind copad_trigger_top copad_trigger_assertions assertions_i (
  .clock, .reset, .event_ready, .out_valid, .out_data, .out_ready
);

`default_nettype wire

//--- verification/copad_trigger_tb.sv
// co-pad trigger testbench
// directed and random events checked against a reference model of the matching rules
`default_nettype none
`timescale 1ns/1ns

module copad_trigger_tb
  import copad_pkg::*;
();

  localparam int n_clusters = 8;
  localparam int wait_limit = 2000; // cycles before a wait gives up

  logic                           clock;
  logic                           reset;
  logic                           event_valid;
  logic                           event_ready;
  cluster_word_t [n_clusters-1:0] gem0_clusters;
  cluster_word_t [n_clusters-1:0] gem1_clusters;
  logic                           match_neighbors;
  logic                           out_valid;
  logic [readout_width-1:0]       out_data;
  logic                           out_ready;

  logic [readout_width-1:0] exp_records[$];   // expected words per kind
  logic [readout_width-1:0] exp_summaries[$];
  logic [tag_width-1:0]     next_tag = '0;    // tag of the next event sent
  int                       errors   = 0;
  int                       rec_seen = 0;
  int                       sum_seen = 0;
  logic                     throttle = 1'b0;  // random out_ready when set
  logic                     hung     = 1'b0;
  string                    hang_reason;

  copad_trigger_top #(.n_clusters(n_clusters)) copad_trigger_top_i (
    .clock, .reset, .event_valid, .event_ready, .gem0_clusters, .gem1_clusters,
    .match_neighbors, .out_valid, .out_data, .out_ready
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // readout sink that stalls at random during the random test
  initial begin
    out_ready = 1'b1;
    forever begin
      @(negedge clock);
      out_ready = throttle ? 1'($urandom % 2) : 1'b1;
    end
  end

  initial begin
    wait (hung === 1'b1);
    $display("Timeout while waiting for %s", hang_reason);
    $display("Verification failed");
    $finish;
  end

  // --------------------
  // reference model
  // --------------------
  function automatic cluster_word_t make_cluster(input int cnt, input int adr);
    cluster_word_t w;
    w.as_hit.cnt = cnt_width'(cnt);
    w.as_hit.adr = adr_width'(adr);
    return w;
  endfunction

  function automatic bit is_blank(input int adr);
    return adr >= 1536; // top two address bits set
  endfunction

  function automatic bit at_left_edge(input int adr);
    return (adr % partition_pads == 0) && (adr <= 7 * partition_pads);
  endfunction

  function automatic bit at_right_edge(input int adr);
    return adr inside {184, 376, 568, 760, 952, 1144, 1528};
  endfunction

  // expected words of the event now on the inputs
  task automatic model_event(input bit nb);
    int                a;
    int                b;
    int                sel;
    bit                c;
    bit                l;
    bit                r;
    bit                any;
    logic [n_febs-1:0] febs;
    any  = 1'b0;
    febs = '0;
    for (int i = 0; i < n_clusters; i++) begin
      a = int'(gem0_clusters[i].as_hit.adr);
      c = 1'b0;
      l = 1'b0;
      r = 1'b0;
      for (int j = 0; j < n_clusters; j++) begin
        b = int'(gem1_clusters[j].as_hit.adr);
        if (!is_blank(a) && !is_blank(b)) begin
          c = c | (b == a);
          l = l | (b == a - neighbor_offset);
          r = r | (b == a + neighbor_offset);
        end
      end
      l = l & !at_left_edge(a);
      r = r & !at_right_edge(a);
      if (c || (nb && (l || r))) begin
        exp_records.push_back({kind_record, next_tag, 3'(i), l, r, gem0_clusters[i], 5'b0});
        any = 1'b1;
        sel = a / 32; // board select is address bits 10:5
        if (sel < n_febs)
          febs = febs | (24'(1) << ((sel % 3) * 8 + sel / 3));
      end
    end
    if (any)
      exp_summaries.push_back({kind_summary, next_tag, febs});
    next_tag = next_tag + 1'b1;
  endtask

  // --------------------
  // scoreboard
  // --------------------
  task automatic check_word(input logic [readout_width-1:0] word);
    logic [readout_width-1:0] want;
    logic [kind_width-1:0]    kind;
    kind = word[readout_width-1 -: kind_width];
    if (kind == kind_record && exp_records.size() != 0) begin
      want = exp_records.pop_front();
      rec_seen++;
    end else if (kind == kind_summary && exp_summaries.size() != 0) begin
      want = exp_summaries.pop_front();
      sum_seen++;
    end else begin
      errors++;
      $display("Error %0t ns: unexpected readout word %h", $time, word);
      return;
    end
    if (word !== want) begin
      errors++;
      $display("Error %0t ns: readout word %h, expected %h", $time, word, want);
    end
  endtask

  always @(posedge clock) begin
    if (!reset && out_valid && out_ready)
      check_word(out_data);
  end

  // --------------------
  // stimulus helpers
  // --------------------
  task automatic halt_on_timeout(input string what);
    hang_reason = what;
    hung        = 1'b1;
    forever @(posedge clock); // watchdog ends the run
  endtask

  task automatic clear_event();
    for (int i = 0; i < n_clusters; i++) begin
      gem0_clusters[i] = make_cluster(0, 2047 - i); // all blank
      gem1_clusters[i] = make_cluster(0, 1600 + i);
    end
  endtask

  // event_ready depends on registers only and is settled at the falling edge
  task automatic send_event(input bit nb);
    int waited;
    waited          = 0;
    match_neighbors = nb;
    event_valid     = 1'b1;
    model_event(nb);
    while (event_ready !== 1'b1) begin
      @(negedge clock);
      waited++;
      if (waited > wait_limit)
        halt_on_timeout("event_ready");
    end
    @(negedge clock);
    event_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_records.size() != 0 || exp_summaries.size() != 0) begin
      @(negedge clock);
      waited++;
      if (waited > wait_limit)
        halt_on_timeout("readout words");
    end
  endtask

  task automatic check_counts(input string name, input int rec0, input int sum0,
                              input int rec_want, input int sum_want);
    if (rec_seen - rec0 != rec_want || sum_seen - sum0 != sum_want) begin
      errors++;
      $display("Error %0t ns: %s test got %0d records and %0d summaries, expected %0d and %0d",
               $time, name, rec_seen - rec0, sum_seen - sum0, rec_want, sum_want);
    end
  endtask

  // --------------------
  // directed tests
  // --------------------
  task automatic test_reset();
    if (event_ready !== 1'b1) begin
      errors++;
      $display("Error %0t ns: event_ready low after reset", $time);
    end
    if (out_valid !== 1'b0) begin
      errors++;
      $display("Error %0t ns: out_valid high after reset", $time);
    end
  endtask

  task automatic test_exact();
    int rec0;
    int sum0;
    rec0 = rec_seen;
    sum0 = sum_seen;
    clear_event();
    gem0_clusters[0] = make_cluster(2, 100);
    gem0_clusters[1] = make_cluster(0, 700);  // no partner
    gem0_clusters[2] = make_cluster(5, 1600); // blank with a blank twin
    gem0_clusters[3] = make_cluster(1, 1200);
    gem1_clusters[0] = make_cluster(0, 1200);
    gem1_clusters[3] = make_cluster(0, 100);
    gem1_clusters[6] = make_cluster(0, 1600);
    send_event(1'b0);
    wait_drain();
    check_counts("exact", rec0, sum0, 2, 1);
  endtask

  task automatic test_neighbors();
    int rec0;
    int sum0;
    rec0 = rec_seen;
    sum0 = sum_seen;
    clear_event();
    gem0_clusters[0] = make_cluster(0, 300);
    gem1_clusters[0] = make_cluster(0, 292);
    gem0_clusters[1] = make_cluster(0, 500);
    gem1_clusters[1] = make_cluster(0, 508);
    gem0_clusters[2] = make_cluster(0, 384);
    gem1_clusters[2] = make_cluster(0, 376);
    gem0_clusters[3] = make_cluster(0, 568);
    gem1_clusters[3] = make_cluster(0, 576);
    gem0_clusters[4] = make_cluster(0, 1144);
    gem1_clusters[4] = make_cluster(0, 1152);
    gem0_clusters[5] = make_cluster(0, 3);    // 3 - 8 wraps to the blank 2043
    gem1_clusters[5] = make_cluster(0, 2043);
    gem0_clusters[6] = make_cluster(0, 1531); // blank partner 8 above
    gem1_clusters[6] = make_cluster(0, 1539);
    gem0_clusters[7] = make_cluster(0, 1536); // blank cluster with a valid partner 8 below
    gem1_clusters[7] = make_cluster(0, 1528);
    send_event(1'b0); // side pairs only give nothing
    send_event(1'b1); // edge pairs at 384, 568 and 1144 stay silent
    wait_drain();
    check_counts("neighbour", rec0, sum0, 2, 1);
  endtask

  task automatic test_feb();
    int rec0;
    int sum0;
    rec0 = rec_seen;
    sum0 = sum_seen;
    clear_event();
    gem0_clusters[0] = make_cluster(0, 5);    // select 0
    gem0_clusters[1] = make_cluster(0, 40);   // select 1
    gem0_clusters[2] = make_cluster(0, 170);  // select 5
    gem0_clusters[3] = make_cluster(0, 740);  // select 23
    gem0_clusters[4] = make_cluster(0, 970);  // select 30 has no board
    for (int i = 0; i < 5; i++)
      gem1_clusters[i] = gem0_clusters[i];
    send_event(1'b0);
    wait_drain();
    clear_event();
    send_event(1'b1); // no match gives no words at all
    repeat (20) @(negedge clock);
    check_counts("FEB summary", rec0, sum0, 5, 1);
  endtask

  task automatic test_random();
    throttle = 1'b1;
    for (int e = 0; e < 40; e++) begin
      for (int i = 0; i < n_clusters; i++) begin
        gem0_clusters[i] = make_cluster($urandom % 8, ($urandom % 200) * 8);
        gem1_clusters[i] = make_cluster($urandom % 8, ($urandom % 200) * 8);
      end
      send_event(1'($urandom % 2));
    end
    wait_drain();
    throttle = 1'b0;
  endtask

  initial begin
    void'($urandom(77));
    reset           = 1'b1;
    event_valid     = 1'b0;
    match_neighbors = 1'b0;
    clear_event();
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    test_reset();
    test_exact();
    test_neighbors();
    test_feb();
    test_random();
    errors = errors + copad_trigger_top_i.assertions_i.failures;
    $display("%0d errors, %0d records and %0d summaries checked", errors, rec_seen, sum_seen);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
design/copad_pkg.sv
design/copad_matcher.sv
design/copad_serializer.sv
design/feb_summary.sv
design/readout_arbiter.sv
design/copad_trigger_top.sv
verification/copad_trigger_assertions.sv
verification/copad_trigger_tb.sv

//--- Makefile
# Verilator build, run, lint and clean for the co-pad trigger slice
VERILATOR ?= verilator
TB_TOP    ?= copad_trigger_tb
RTL_TOP   ?= copad_trigger_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

SOURCES   := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS  := $(filter design/%,$(SOURCES))
SIM_BIN   := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@grep -q "Verification passed" $(LOG) || { echo "FAIL: run ended early, see $(LOG)"; exit 1; }
	@echo "PASS"

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
